// File: flist.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/control_decoder.sv
rtl/register_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/arm_cpu.sv
dv/arm_cpu_sva.sv
dv/arm_cpu_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := arm_cpu_tb
FLIST      := flist.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
RUN_ARGS   := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# Simulator exit status carries the result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/arm_cpu_tb.sv
////////////////////
// LEGv8 pipeline testbench
// Memory models, register model and directed tests
////////////////////
`timescale 1ns/1ps

module arm_cpu_tb;

  localparam int IMEM_WORDS = 64;
  localparam int TIMEOUT    = 200;

  logic                        CLOCK;
  logic                        rst_n;
  logic [cpu_pkg::INSTR_W-1:0] instr;
  logic [cpu_pkg::XLEN-1:0]    mem_rdata;
  logic [cpu_pkg::XLEN-1:0]    pc;
  logic [cpu_pkg::XLEN-1:0]    mem_addr;
  logic [cpu_pkg::XLEN-1:0]    mem_wdata;
  logic                        mem_read;
  logic                        mem_write;

  logic [cpu_pkg::INSTR_W-1:0] imem [IMEM_WORDS];
  logic [cpu_pkg::XLEN-1:0]    dmem [logic [cpu_pkg::XLEN-1:0]];
  logic [cpu_pkg::XLEN-1:0]    model [32];  // Architectural registers
  logic [cpu_pkg::XLEN-1:0]    seen_addr [$];
  logic [cpu_pkg::XLEN-1:0]    seen_data [$];
  logic [cpu_pkg::XLEN-1:0]    exp_addr_q [$];
  logic [cpu_pkg::XLEN-1:0]    exp_data_q [$];
  logic [31:0]                 rnd;

  arm_cpu #(.RESET_PC('0)) i_dut (
    .CLOCK, .rst_n, .instr, .mem_rdata,
    .pc, .mem_addr, .mem_wdata, .mem_read, .mem_write
  );

  bind arm_cpu arm_cpu_sva i_sva (
    .CLOCK(CLOCK), .rst_n(rst_n), .pc(pc), .mem_read(mem_read), .mem_write(mem_write),
    .branch_taken(branch_taken), .branch_target(branch_target)
  );

  initial begin
    CLOCK = 1'b0;
    forever #5 CLOCK = ~CLOCK;
  end

  function automatic logic [cpu_pkg::XLEN-1:0] data_word(input logic [cpu_pkg::XLEN-1:0] addr);
    if (dmem.exists(addr)) begin
      return dmem[addr];
    end
    return addr * 64'd5;  // Unwritten word
  endfunction

  assign instr     = (pc < 64'(IMEM_WORDS * 4)) ? imem[pc[7:2]] : '0;
  assign mem_rdata = mem_read ? data_word(mem_addr) : '0;

  always @(posedge CLOCK) begin
    if (mem_write) begin
      seen_addr.push_back(mem_addr);
      seen_data.push_back(mem_wdata);
      dmem[mem_addr] = mem_wdata;
    end
  end

  function automatic logic [cpu_pkg::XLEN-1:0] sext9(input logic [8:0] v);
    return {{(cpu_pkg::XLEN-9){v[8]}}, v};
  endfunction

  function automatic logic [31:0] enc_r(input logic [10:0] op, input logic [4:0] rd,
                                        input logic [4:0] rn, input logic [4:0] rm);
    return {op, rm, 6'd0, rn, rd};
  endfunction

  function automatic logic [31:0] enc_d(input logic [10:0] op, input logic [4:0] rt,
                                        input logic [4:0] rn, input logic [8:0] off);
    return {op, off, 2'b00, rn, rt};
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopping after the first error");
  endtask

  task automatic check_pc(input logic [cpu_pkg::XLEN-1:0] exp);
    if (pc !== exp) begin
      fail_now($sformatf("[FAIL] pc exp=%h got=%h", exp, pc));
    end
  endtask

  task automatic check_strobe(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      fail_now($sformatf("[FAIL] %s exp=%h got=%h", name, exp, got));
    end
  endtask

  task automatic check_store(input logic [cpu_pkg::XLEN-1:0] exp_addr,
                             input logic [cpu_pkg::XLEN-1:0] exp_data);
    int n;
    logic [cpu_pkg::XLEN-1:0] got_addr;
    logic [cpu_pkg::XLEN-1:0] got_data;
    n = 0;
    while (seen_addr.size() == 0) begin
      if (n == TIMEOUT) begin
        fail_now("timed out waiting for a store from the DUT");
      end
      n++;
      @(negedge CLOCK);
    end
    got_addr = seen_addr.pop_front();
    got_data = seen_data.pop_front();
    if (got_addr !== exp_addr) begin
      fail_now($sformatf("[FAIL] mem_addr exp=%h got=%h", exp_addr, got_addr));
    end
    if (got_data !== exp_data) begin
      fail_now($sformatf("[FAIL] mem_wdata exp=%h got=%h", exp_data, got_data));
    end
  endtask

  task automatic check_stores();
    logic [cpu_pkg::XLEN-1:0] a;
    logic [cpu_pkg::XLEN-1:0] d;
    while (exp_addr_q.size() != 0) begin
      a = exp_addr_q.pop_front();
      d = exp_data_q.pop_front();
      check_store(a, d);
    end
    repeat (10) @(negedge CLOCK);
    if (seen_addr.size() != 0) begin
      fail_now("the DUT made a store that the program does not contain");
    end
  endtask

  task automatic wait_pc(input logic [cpu_pkg::XLEN-1:0] target);
    int n;
    n = 0;
    while (pc !== target) begin
      if (n == TIMEOUT) begin
        fail_now($sformatf("timed out waiting for pc to reach %h", target));
      end
      n++;
      @(negedge CLOCK);
    end
  endtask

  task automatic hold_reset();
    @(posedge CLOCK);
    rst_n <= 1'b0;
    @(posedge CLOCK);
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = '0;  // NOP fill
    end
    dmem.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
    for (int i = 0; i < 32; i++) begin
      model[i] = 64'(i);
    end
    model[cpu_pkg::ZERO_REG] = '0;
  endtask

  task automatic release_reset();
    repeat (7) @(posedge CLOCK);
    seen_addr.delete();
    seen_data.delete();
    rst_n <= 1'b1;
    @(negedge CLOCK);
  endtask

  task automatic program_alu(input int idx, input cpu_pkg::opcode_e op, input logic [4:0] rd,
                             input logic [4:0] rn, input logic [4:0] rm);
    logic [cpu_pkg::XLEN-1:0] res;
    case (op)
      cpu_pkg::OP_ADD: res = model[rn] + model[rm];
      cpu_pkg::OP_SUB: res = model[rn] - model[rm];
      cpu_pkg::OP_AND: res = model[rn] & model[rm];
      default:         res = model[rn] | model[rm];
    endcase
    imem[idx] = enc_r(op, rd, rn, rm);
    if (rd != cpu_pkg::ZERO_REG) begin
      model[rd] = res;
    end
  endtask

  task automatic program_load(input int idx, input logic [4:0] rt, input logic [4:0] rn,
                              input logic [8:0] off);
    imem[idx] = enc_d(cpu_pkg::OP_LDUR, rt, rn, off);
    model[rt] = (model[rn] + sext9(off)) * 64'd5;
  endtask

  // live is low for instructions that a taken branch skips
  task automatic program_store(input int idx, input logic [4:0] rt, input logic [4:0] rn,
                               input logic [8:0] off, input bit live);
    imem[idx] = enc_d(cpu_pkg::OP_STUR, rt, rn, off);
    if (live) begin
      exp_addr_q.push_back(model[rn] + sext9(off));
      exp_data_q.push_back(model[rt]);
    end
  endtask

  task automatic reset_test();
    hold_reset();
    program_store(0, 5'd3, 5'd7, rnd[8:0], 1'b1);
    program_store(1, 5'd12, 5'd20, rnd[17:9], 1'b1);
    @(negedge CLOCK);
    check_pc('0);
    check_strobe("mem_read", 1'b0, mem_read);
    check_strobe("mem_write", 1'b0, mem_write);
    release_reset();
    check_pc('0);
    check_strobe("mem_read", 1'b0, mem_read);
    check_strobe("mem_write", 1'b0, mem_write);
    check_stores();
  endtask

  task automatic alu_forwarding_test();
    hold_reset();
    program_alu(0, cpu_pkg::OP_ADD, 5'd9, 5'd3, 5'd5);
    program_alu(1, cpu_pkg::OP_SUB, 5'd10, 5'd9, 5'd2);    // Distance 1
    program_alu(2, cpu_pkg::OP_AND, 5'd11, 5'd9, 5'd14);   // Distance 2
    program_alu(3, cpu_pkg::OP_ORR, 5'd12, 5'd9, 5'd10);   // Distance 3 and 2
    program_alu(4, cpu_pkg::OP_ADD, 5'd13, 5'd12, 5'd11);
    program_alu(5, cpu_pkg::OP_SUB, 5'd15, 5'd13, 5'd12);
    program_store(6, 5'd9, 5'd1, 9'h10, 1'b1);
    program_store(7, 5'd10, 5'd1, 9'h18, 1'b1);
    program_store(8, 5'd11, 5'd1, 9'h20, 1'b1);
    program_store(9, 5'd12, 5'd1, 9'h28, 1'b1);
    program_store(10, 5'd13, 5'd1, 9'h30, 1'b1);
    program_store(11, 5'd15, 5'd1, 9'h38, 1'b1);
    release_reset();
    check_stores();
  endtask

  task automatic load_use_test();
    hold_reset();
    program_load(0, 5'd6, 5'd2, rnd[26:18]);
    program_alu(1, cpu_pkg::OP_ADD, 5'd7, 5'd6, 5'd4);
    program_store(2, 5'd7, 5'd1, 9'h40, 1'b1);
    release_reset();
    wait_pc(64'd8);
    @(negedge CLOCK);
    check_pc(64'd8);  // One bubble
    @(negedge CLOCK);
    check_pc(64'd12);
    check_stores();
  endtask

  task automatic zero_reg_test();
    hold_reset();
    program_alu(0, cpu_pkg::OP_ADD, 5'd31, 5'd3, 5'd4);
    program_alu(1, cpu_pkg::OP_ADD, 5'd8, 5'd31, 5'd5);
    program_store(2, 5'd31, 5'd2, 9'h20, 1'b1);
    program_store(3, 5'd8, 5'd2, 9'h28, 1'b1);
    release_reset();
    check_stores();
  endtask

  task automatic branch_test();
    hold_reset();
    imem[0] = {cpu_pkg::CBZ_PREFIX, 19'd5, 5'd0};  // Taken to word 5
    program_store(1, 5'd1, 5'd2, 9'h50, 1'b1);
    program_store(2, 5'd3, 5'd2, 9'h58, 1'b1);
    program_store(3, 5'd4, 5'd2, 9'h60, 1'b1);
    program_store(4, 5'd5, 5'd2, 9'h68, 1'b0);
    program_store(5, 5'd6, 5'd2, 9'h70, 1'b1);
    imem[6] = {cpu_pkg::CBZ_PREFIX, 19'd6, 5'd7};  // X7 nonzero
    for (int i = 7; i < 12; i++) begin
      program_store(i, 5'(i + 1), 5'd2, 9'(8 * i + 'h40), 1'b1);
    end
    imem[12] = {cpu_pkg::B_PREFIX, 26'd5};  // To word 17
    program_store(13, 5'd13, 5'd2, 9'h90, 1'b1);
    program_store(14, 5'd14, 5'd2, 9'h98, 1'b1);
    program_store(15, 5'd15, 5'd2, 9'ha0, 1'b1);
    program_store(16, 5'd18, 5'd2, 9'ha8, 1'b0);
    program_store(17, 5'd19, 5'd2, 9'hb0, 1'b1);
    release_reset();
    wait_pc(64'd60);
    @(negedge CLOCK);
    check_pc(64'd68);
    check_stores();
  endtask

  initial begin
    rst_n = 1'b0;
    rnd   = $urandom(32'h66769044);
    reset_test();
    alu_forwarding_test();
    load_use_test();
    zero_reg_test();
    branch_test();
    if (i_dut.i_sva.fail_count != 0) begin
      fail_now("assertions on the DUT ports failed during the run");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// File: dv/arm_cpu_sva.sv
////////////////////
// Port checks for the pipeline
// Strobes and pc stepping
////////////////////
`timescale 1ns/1ps

module arm_cpu_sva (
  input logic                     CLOCK,
  input logic                     rst_n,
  input logic [cpu_pkg::XLEN-1:0] pc,
  input logic                     mem_read,
  input logic                     mem_write,
  input logic                     branch_taken,
  input logic [cpu_pkg::XLEN-1:0] branch_target
);

  int unsigned fail_count = 0;

  property strobes_exclusive;
    @(posedge CLOCK) disable iff (!rst_n) !(mem_read && mem_write);
  endproperty

  property strobes_quiet_in_reset;
    @(posedge CLOCK) !rst_n |-> (!mem_read && !mem_write);
  endproperty

  // Step, hold for a stall, or redirect
  property pc_step;
    @(posedge CLOCK) disable iff (!rst_n)
      $past(rst_n) |-> ((pc == $past(pc) + 64'd4) || (pc == $past(pc)) ||
                        ($past(branch_taken) && pc == $past(branch_target)));
  endproperty

  a_strobes_exclusive: assert property (strobes_exclusive) else begin
    fail_count++;
    $error("mem_read and mem_write high together");
  end

  a_strobes_reset: assert property (strobes_quiet_in_reset) else begin
    fail_count++;
    $error("memory strobe active during reset");
  end

  a_pc_step: assert property (pc_step) else begin
    fail_count++;
    $error("pc moved to a value other than pc+4, pc or a branch target");
  end

endmodule

// File: rtl/arm_cpu.sv
////////////////////
// LEGv8 five-stage pipelined core
// Fetch, decode, execute, memory and writeback
////////////////////
`timescale 1ns/1ps

module arm_cpu #(
  parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                       CLOCK,
  input  logic                       rst_n,
  input  logic [cpu_pkg::INSTR_W-1:0] instr,
  input  logic [cpu_pkg::XLEN-1:0]    mem_rdata,
  output logic [cpu_pkg::XLEN-1:0]    pc,
  output logic [cpu_pkg::XLEN-1:0]    mem_addr,
  output logic [cpu_pkg::XLEN-1:0]    mem_wdata,
  output logic                       mem_read,
  output logic                       mem_write
);

  logic                       stall;
  logic                       branch_taken;
  logic [cpu_pkg::XLEN-1:0]    branch_target;
  logic [cpu_pkg::XLEN-1:0]    if_id_pc;
  logic [cpu_pkg::INSTR_W-1:0] if_id_instr;

  cpu_pkg::alu_op_e           id_ex_alu_op;
  logic                       id_ex_alu_src;
  logic                       id_ex_zero_branch;
  logic                       id_ex_uncond_branch;
  logic                       id_ex_mem_read;
  logic                       id_ex_mem_write;
  logic                       id_ex_reg_write;
  logic                       id_ex_mem_to_reg;
  logic [cpu_pkg::XLEN-1:0]    id_ex_pc;
  logic [cpu_pkg::XLEN-1:0]    id_ex_rs1_data;
  logic [cpu_pkg::XLEN-1:0]    id_ex_rs2_data;
  logic [cpu_pkg::XLEN-1:0]    id_ex_imm;
  logic [10:0]                id_ex_opcode;
  logic [cpu_pkg::REG_AW-1:0]  id_ex_rd;
  logic [cpu_pkg::REG_AW-1:0]  id_ex_rs1;
  logic [cpu_pkg::REG_AW-1:0]  id_ex_rs2;

  logic [cpu_pkg::REG_AW-1:0]  ex_mem_rd;
  logic                       ex_mem_reg_write;
  logic                       ex_mem_mem_to_reg;
  logic                       zero_branch;
  logic                       uncond_branch;
  logic                       alu_zero;

  logic                       wb_en;
  logic [cpu_pkg::REG_AW-1:0]  wb_reg;
  logic [cpu_pkg::XLEN-1:0]    wb_data;

  fetch_stage #(.RESET_PC(RESET_PC)) i_fetch (
    .CLOCK, .rst_n, .stall, .branch_taken, .branch_target, .instr,
    .pc, .if_id_pc, .if_id_instr
  );

  decode_stage i_decode (
    .CLOCK, .rst_n, .if_id_pc, .if_id_instr, .wb_en, .wb_reg, .wb_data, .stall,
    .id_ex_alu_op, .id_ex_alu_src, .id_ex_zero_branch, .id_ex_uncond_branch,
    .id_ex_mem_read, .id_ex_mem_write, .id_ex_reg_write, .id_ex_mem_to_reg,
    .id_ex_pc, .id_ex_rs1_data, .id_ex_rs2_data, .id_ex_imm, .id_ex_opcode,
    .id_ex_rd, .id_ex_rs1, .id_ex_rs2
  );

  execute_stage i_execute (
    .CLOCK, .rst_n,
    .id_ex_alu_op, .id_ex_alu_src, .id_ex_zero_branch, .id_ex_uncond_branch,
    .id_ex_mem_read, .id_ex_mem_write, .id_ex_reg_write, .id_ex_mem_to_reg,
    .id_ex_pc, .id_ex_rs1_data, .id_ex_rs2_data, .id_ex_imm, .id_ex_opcode,
    .id_ex_rd, .id_ex_rs1, .id_ex_rs2,
    .mem_fwd_data(mem_addr), .wb_en, .wb_reg, .wb_data,
    .ex_mem_rd, .ex_mem_reg_write, .ex_mem_mem_to_reg, .zero_branch, .uncond_branch,
    .alu_zero, .branch_target, .mem_addr, .mem_wdata, .mem_read, .mem_write
  );

  memory_stage i_memory (
    .CLOCK, .rst_n, .ex_mem_rd, .ex_mem_reg_write, .ex_mem_mem_to_reg,
    .zero_branch, .uncond_branch, .alu_zero, .mem_addr, .mem_rdata,
    .branch_taken, .wb_en, .wb_reg, .wb_data
  );

endmodule

// File: rtl/memory_stage.sv
////////////////////
// Memory stage
// Branch decision, MEM/WB register and writeback select
////////////////////
`timescale 1ns/1ps

module memory_stage (
  input  logic                      CLOCK,
  input  logic                      rst_n,
  input  logic [cpu_pkg::REG_AW-1:0] ex_mem_rd,
  input  logic                      ex_mem_reg_write,
  input  logic                      ex_mem_mem_to_reg,
  input  logic                      zero_branch,
  input  logic                      uncond_branch,
  input  logic                      alu_zero,
  input  logic [cpu_pkg::XLEN-1:0]   mem_addr,
  input  logic [cpu_pkg::XLEN-1:0]   mem_rdata,
  output logic                      branch_taken,
  output logic                      wb_en,
  output logic [cpu_pkg::REG_AW-1:0] wb_reg,
  output logic [cpu_pkg::XLEN-1:0]   wb_data
);

  logic                     mem_wb_mem_to_reg;
  logic [cpu_pkg::XLEN-1:0] mem_wb_result;
  logic [cpu_pkg::XLEN-1:0] mem_wb_rdata;

  assign branch_taken = uncond_branch || (zero_branch && alu_zero);

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      wb_en             <= 1'b0;
      mem_wb_mem_to_reg <= 1'b0;
    end else begin
      wb_en             <= ex_mem_reg_write;
      mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
    end
  end

  always_ff @(posedge CLOCK) begin
    wb_reg        <= ex_mem_rd;
    mem_wb_result <= mem_addr;  // ALU result doubles as the address
    mem_wb_rdata  <= mem_rdata;
  end

  assign wb_data = mem_wb_mem_to_reg ? mem_wb_rdata : mem_wb_result;

endmodule

// File: rtl/execute_stage.sv
////////////////////
// Execute stage
// Forwarding, ALU control, branch target and EX/MEM register
////////////////////
`timescale 1ns/1ps

module execute_stage (
  input  logic                      CLOCK,
  input  logic                      rst_n,
  input  cpu_pkg::alu_op_e          id_ex_alu_op,
  input  logic                      id_ex_alu_src,
  input  logic                      id_ex_zero_branch,
  input  logic                      id_ex_uncond_branch,
  input  logic                      id_ex_mem_read,
  input  logic                      id_ex_mem_write,
  input  logic                      id_ex_reg_write,
  input  logic                      id_ex_mem_to_reg,
  input  logic [cpu_pkg::XLEN-1:0]   id_ex_pc,
  input  logic [cpu_pkg::XLEN-1:0]   id_ex_rs1_data,
  input  logic [cpu_pkg::XLEN-1:0]   id_ex_rs2_data,
  input  logic [cpu_pkg::XLEN-1:0]   id_ex_imm,
  input  logic [10:0]               id_ex_opcode,
  input  logic [cpu_pkg::REG_AW-1:0] id_ex_rd,
  input  logic [cpu_pkg::REG_AW-1:0] id_ex_rs1,
  input  logic [cpu_pkg::REG_AW-1:0] id_ex_rs2,
  input  logic [cpu_pkg::XLEN-1:0]   mem_fwd_data,
  input  logic                      wb_en,
  input  logic [cpu_pkg::REG_AW-1:0] wb_reg,
  input  logic [cpu_pkg::XLEN-1:0]   wb_data,
  output logic [cpu_pkg::REG_AW-1:0] ex_mem_rd,
  output logic                      ex_mem_reg_write,
  output logic                      ex_mem_mem_to_reg,
  output logic                      zero_branch,
  output logic                      uncond_branch,
  output logic                      alu_zero,
  output logic [cpu_pkg::XLEN-1:0]   branch_target,
  output logic [cpu_pkg::XLEN-1:0]   mem_addr,
  output logic [cpu_pkg::XLEN-1:0]   mem_wdata,
  output logic                      mem_read,
  output logic                      mem_write
);

  cpu_pkg::fwd_sel_e        fwd_a;
  cpu_pkg::fwd_sel_e        fwd_b;
  cpu_pkg::alu_ctrl_e       alu_ctrl;
  logic [cpu_pkg::XLEN-1:0] op_a;
  logic [cpu_pkg::XLEN-1:0] op_b;
  logic [cpu_pkg::XLEN-1:0] alu_result;
  logic                     zero;

  // WB is checked before MEM
  function automatic cpu_pkg::fwd_sel_e fwd_pick(input logic [cpu_pkg::REG_AW-1:0] rs);
    if (wb_en && wb_reg != cpu_pkg::ZERO_REG && wb_reg == rs) begin
      return cpu_pkg::FWD_WB;
    end else if (ex_mem_reg_write && ex_mem_rd != cpu_pkg::ZERO_REG && ex_mem_rd == rs) begin
      return cpu_pkg::FWD_MEM;
    end
    return cpu_pkg::FWD_NONE;
  endfunction

  function automatic logic [cpu_pkg::XLEN-1:0] fwd_mux(input cpu_pkg::fwd_sel_e sel,
                                                      input logic [cpu_pkg::XLEN-1:0] rf);
    case (sel)
      cpu_pkg::FWD_WB:  return wb_data;
      cpu_pkg::FWD_MEM: return mem_fwd_data;
      default:          return rf;
    endcase
  endfunction

  always_comb begin
    fwd_a = fwd_pick(id_ex_rs1);
    fwd_b = fwd_pick(id_ex_rs2);
    op_a  = fwd_mux(fwd_a, id_ex_rs1_data);
    op_b  = fwd_mux(fwd_b, id_ex_rs2_data);
  end

  always_comb begin
    case (id_ex_alu_op)
      cpu_pkg::ALUOP_PASS: alu_ctrl = cpu_pkg::ALU_PASS_B;
      cpu_pkg::ALUOP_RTYPE: begin
        case (id_ex_opcode)
          cpu_pkg::OP_SUB: alu_ctrl = cpu_pkg::ALU_SUB;
          cpu_pkg::OP_AND: alu_ctrl = cpu_pkg::ALU_AND;
          cpu_pkg::OP_ORR: alu_ctrl = cpu_pkg::ALU_ORR;
          default:         alu_ctrl = cpu_pkg::ALU_ADD;
        endcase
      end
      default: alu_ctrl = cpu_pkg::ALU_ADD;
    endcase
  end

  alu i_alu (
    .a(op_a),
    .b(id_ex_alu_src ? id_ex_imm : op_b),
    .op(alu_ctrl),
    .result(alu_result),
    .zero
  );

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem_reg_write  <= 1'b0;
      ex_mem_mem_to_reg <= 1'b0;
      zero_branch       <= 1'b0;
      uncond_branch     <= 1'b0;
      mem_read          <= 1'b0;
      mem_write         <= 1'b0;
    end else begin
      ex_mem_reg_write  <= id_ex_reg_write;
      ex_mem_mem_to_reg <= id_ex_mem_to_reg;
      zero_branch       <= id_ex_zero_branch;
      uncond_branch     <= id_ex_uncond_branch;
      mem_read          <= id_ex_mem_read;
      mem_write         <= id_ex_mem_write;
    end
  end

  always_ff @(posedge CLOCK) begin
    ex_mem_rd     <= id_ex_rd;
    alu_zero      <= zero;
    branch_target <= id_ex_pc + (id_ex_imm << 2);  // Word offset
    mem_addr      <= alu_result;
    mem_wdata     <= op_b;  // Store data after forwarding
  end

endmodule

// File: rtl/decode_stage.sv
////////////////////
// Decode stage
// Operand read, immediates, load-use stall and ID/EX register
////////////////////
`timescale 1ns/1ps

module decode_stage (
  input  logic                       CLOCK,
  input  logic                       rst_n,
  input  logic [cpu_pkg::XLEN-1:0]    if_id_pc,
  input  logic [cpu_pkg::INSTR_W-1:0] if_id_instr,
  input  logic                       wb_en,
  input  logic [cpu_pkg::REG_AW-1:0]  wb_reg,
  input  logic [cpu_pkg::XLEN-1:0]    wb_data,
  output logic                       stall,
  output cpu_pkg::alu_op_e           id_ex_alu_op,
  output logic                       id_ex_alu_src,
  output logic                       id_ex_zero_branch,
  output logic                       id_ex_uncond_branch,
  output logic                       id_ex_mem_read,
  output logic                       id_ex_mem_write,
  output logic                       id_ex_reg_write,
  output logic                       id_ex_mem_to_reg,
  output logic [cpu_pkg::XLEN-1:0]    id_ex_pc,
  output logic [cpu_pkg::XLEN-1:0]    id_ex_rs1_data,
  output logic [cpu_pkg::XLEN-1:0]    id_ex_rs2_data,
  output logic [cpu_pkg::XLEN-1:0]    id_ex_imm,
  output logic [10:0]                id_ex_opcode,
  output logic [cpu_pkg::REG_AW-1:0]  id_ex_rd,
  output logic [cpu_pkg::REG_AW-1:0]  id_ex_rs1,
  output logic [cpu_pkg::REG_AW-1:0]  id_ex_rs2
);

  logic [cpu_pkg::REG_AW-1:0] rs1;
  logic [cpu_pkg::REG_AW-1:0] rs2;
  logic [cpu_pkg::XLEN-1:0]   rs1_data;
  logic [cpu_pkg::XLEN-1:0]   rs2_data;
  logic [cpu_pkg::XLEN-1:0]   imm;
  cpu_pkg::alu_op_e           alu_op;
  logic                       alu_src;
  logic                       zero_branch;
  logic                       uncond_branch;
  logic                       mem_read;
  logic                       mem_write;
  logic                       reg_write;
  logic                       mem_to_reg;

  assign rs1 = if_id_instr[9:5];
  assign rs2 = if_id_instr[28] ? if_id_instr[4:0] : if_id_instr[20:16];  // Rt for STUR and CBZ

  control_decoder i_ctrl (
    .opcode(if_id_instr[31:21]),
    .alu_op, .alu_src, .zero_branch, .uncond_branch,
    .mem_read, .mem_write, .reg_write, .mem_to_reg
  );

  register_file i_rf (
    .CLOCK, .rst_n,
    .rd_addr1(rs1), .rd_addr2(rs2),
    .wb_en, .wb_reg, .wb_data,
    .rd_data1(rs1_data), .rd_data2(rs2_data)
  );

  always_comb begin
    if (if_id_instr[31:26] == cpu_pkg::B_PREFIX) begin
      imm = {{(cpu_pkg::XLEN-26){if_id_instr[25]}}, if_id_instr[25:0]};
    end else if (if_id_instr[31:24] == cpu_pkg::CBZ_PREFIX) begin
      imm = {{(cpu_pkg::XLEN-19){if_id_instr[23]}}, if_id_instr[23:5]};
    end else begin
      imm = {{(cpu_pkg::XLEN-9){if_id_instr[20]}}, if_id_instr[20:12]};  // D-type offset
    end
  end

  // Load in EX feeding the instruction in ID
  assign stall = id_ex_mem_read && (id_ex_rd == rs1 || id_ex_rd == rs2);

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_alu_op        <= cpu_pkg::ALUOP_ADDR;
      id_ex_alu_src       <= 1'b0;
      id_ex_zero_branch   <= 1'b0;
      id_ex_uncond_branch <= 1'b0;
      id_ex_mem_read      <= 1'b0;
      id_ex_mem_write     <= 1'b0;
      id_ex_reg_write     <= 1'b0;
      id_ex_mem_to_reg    <= 1'b0;
    end else begin
      id_ex_alu_op        <= stall ? cpu_pkg::ALUOP_ADDR : alu_op;  // Bubble on stall
      id_ex_alu_src       <= alu_src & ~stall;
      id_ex_zero_branch   <= zero_branch & ~stall;
      id_ex_uncond_branch <= uncond_branch & ~stall;
      id_ex_mem_read      <= mem_read & ~stall;
      id_ex_mem_write     <= mem_write & ~stall;
      id_ex_reg_write     <= reg_write & ~stall;
      id_ex_mem_to_reg    <= mem_to_reg & ~stall;
    end
  end

  always_ff @(posedge CLOCK) begin
    id_ex_pc       <= if_id_pc;
    id_ex_rs1_data <= rs1_data;
    id_ex_rs2_data <= rs2_data;
    id_ex_imm      <= imm;
    id_ex_opcode   <= if_id_instr[31:21];
    id_ex_rd       <= if_id_instr[4:0];
    id_ex_rs1      <= rs1;
    id_ex_rs2      <= rs2;
  end

endmodule

// File: rtl/fetch_stage.sv
////////////////////
// Fetch stage
// Program counter and IF/ID register
////////////////////
`timescale 1ns/1ps

module fetch_stage #(
  parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                       CLOCK,
  input  logic                       rst_n,
  input  logic                       stall,
  input  logic                       branch_taken,
  input  logic [cpu_pkg::XLEN-1:0]    branch_target,
  input  logic [cpu_pkg::INSTR_W-1:0] instr,
  output logic [cpu_pkg::XLEN-1:0]    pc,
  output logic [cpu_pkg::XLEN-1:0]    if_id_pc,
  output logic [cpu_pkg::INSTR_W-1:0] if_id_instr
);

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (branch_taken) begin  // Redirect wins over a stall
      pc <= branch_target;
    end else if (!stall) begin
      pc <= pc + cpu_pkg::XLEN'(4);
    end
  end

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      if_id_pc    <= '0;
      if_id_instr <= '0;  // Decodes as a NOP
    end else if (!stall) begin
      if_id_pc    <= pc;
      if_id_instr <= instr;
    end
  end

endmodule

// File: rtl/register_file.sv
////////////////////
// Register file
// 32 x 64 with write-through and X31 as zero
////////////////////
`timescale 1ns/1ps

module register_file (
  input  logic                      CLOCK,
  input  logic                      rst_n,
  input  logic [cpu_pkg::REG_AW-1:0] rd_addr1,
  input  logic [cpu_pkg::REG_AW-1:0] rd_addr2,
  input  logic                      wb_en,
  input  logic [cpu_pkg::REG_AW-1:0] wb_reg,
  input  logic [cpu_pkg::XLEN-1:0]   wb_data,
  output logic [cpu_pkg::XLEN-1:0]   rd_data1,
  output logic [cpu_pkg::XLEN-1:0]   rd_data2
);

  logic [cpu_pkg::XLEN-1:0] regs [32];

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= cpu_pkg::XLEN'(i);  // Xi starts at i
      end
    end else if (wb_en && wb_reg != cpu_pkg::ZERO_REG) begin
      regs[wb_reg] <= wb_data;
    end
  end

  assign rd_data1 = (rd_addr1 == cpu_pkg::ZERO_REG) ? '0 :
                    (wb_en && wb_reg == rd_addr1) ? wb_data : regs[rd_addr1];
  assign rd_data2 = (rd_addr2 == cpu_pkg::ZERO_REG) ? '0 :
                    (wb_en && wb_reg == rd_addr2) ? wb_data : regs[rd_addr2];

endmodule

// File: rtl/control_decoder.sv
////////////////////
// Main control decoder
// Maps the 11-bit opcode to per-stage control bits
////////////////////
`timescale 1ns/1ps

module control_decoder (
  input  logic [10:0]      opcode,
  output cpu_pkg::alu_op_e alu_op,
  output logic             alu_src,
  output logic             zero_branch,
  output logic             uncond_branch,
  output logic             mem_read,
  output logic             mem_write,
  output logic             reg_write,
  output logic             mem_to_reg
);

  always_comb begin
    alu_op        = cpu_pkg::ALUOP_ADDR;
    alu_src       = 1'b0;
    zero_branch   = 1'b0;
    uncond_branch = 1'b0;
    mem_read      = 1'b0;
    mem_write     = 1'b0;
    reg_write     = 1'b0;
    mem_to_reg    = 1'b0;

    if (opcode[10:5] == cpu_pkg::B_PREFIX) begin
      alu_op        = cpu_pkg::ALUOP_PASS;
      uncond_branch = 1'b1;
    end else if (opcode[10:3] == cpu_pkg::CBZ_PREFIX) begin
      alu_op      = cpu_pkg::ALUOP_PASS;
      zero_branch = 1'b1;
    end else begin
      case (opcode)
        cpu_pkg::OP_LDUR: begin
          alu_src    = 1'b1;
          mem_read   = 1'b1;
          reg_write  = 1'b1;
          mem_to_reg = 1'b1;
        end
        cpu_pkg::OP_STUR: begin
          alu_src   = 1'b1;
          mem_write = 1'b1;
        end
        cpu_pkg::OP_ADD,
        cpu_pkg::OP_SUB,
        cpu_pkg::OP_AND,
        cpu_pkg::OP_ORR: begin
          alu_op    = cpu_pkg::ALUOP_RTYPE;
          reg_write = 1'b1;
        end
        default: ;  // Unknown opcode runs as a NOP
      endcase
    end
  end

endmodule

// File: rtl/alu.sv
////////////////////
// 64-bit ALU
////////////////////
`timescale 1ns/1ps

module alu (
  input  logic [cpu_pkg::XLEN-1:0] a,
  input  logic [cpu_pkg::XLEN-1:0] b,
  input  cpu_pkg::alu_ctrl_e       op,
  output logic [cpu_pkg::XLEN-1:0] result,
  output logic                     zero
);

  always_comb begin
    case (op)
      cpu_pkg::ALU_AND:    result = a & b;
      cpu_pkg::ALU_ORR:    result = a | b;
      cpu_pkg::ALU_ADD:    result = a + b;
      cpu_pkg::ALU_SUB:    result = a - b;
      cpu_pkg::ALU_PASS_B: result = b;
      default:             result = '0;
    endcase
  end

  assign zero = (result == '0);  // CBZ condition

endmodule

// File: rtl/cpu_pkg.sv
////////////////////
// LEGv8 core definitions
// Widths, opcodes and pipeline control encodings
////////////////////
package cpu_pkg;

  localparam int XLEN    = 64;
  localparam int INSTR_W = 32;
  localparam int REG_AW  = 5;

  localparam logic [REG_AW-1:0] ZERO_REG = 5'd31;  // X31 reads as zero

  typedef enum logic [10:0] {
    OP_LDUR = 11'b11111000010,
    OP_STUR = 11'b11111000000,
    OP_ADD  = 11'b10001011000,
    OP_SUB  = 11'b11001011000,
    OP_AND  = 11'b10001010000,
    OP_ORR  = 11'b10101010000
  } opcode_e;

  // Branches are matched on the upper opcode bits only
  localparam logic [5:0] B_PREFIX   = 6'b000101;
  localparam logic [7:0] CBZ_PREFIX = 8'b10110100;

  typedef enum logic [1:0] {
    ALUOP_ADDR  = 2'b00,  // Address add for loads and stores
    ALUOP_PASS  = 2'b01,  // CBZ tests operand B
    ALUOP_RTYPE = 2'b10
  } alu_op_e;

  typedef enum logic [3:0] {
    ALU_AND    = 4'b0000,
    ALU_ORR    = 4'b0001,
    ALU_ADD    = 4'b0010,
    ALU_SUB    = 4'b0110,
    ALU_PASS_B = 4'b0111
  } alu_ctrl_e;

  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_WB   = 2'b01,
    FWD_MEM  = 2'b10
  } fwd_sel_e;

endpackage
